// ==== rvPkg.sv ====
package rvPkg;

    // word-wide data, addresses and instructions
    typedef logic [31:0] wordT;

    // register index, x0..x31
    typedef logic [4:0] regIdxT;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opI      = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111
    } opcodeT;

    // alu operation select
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluPassB
    } aluCtrlT;

    // immediate format select
    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU
    } immSrcT;

    // funct3 codes
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

endpackage

// ==== fetchUnit.sv ====
module fetchUnit import rvPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic clk,
    input  logic rstN_i,
    input  logic pcSrc_i,
    input  wordT immExt_i,
    output wordT pc_o
);

    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] pcTarget;
    logic [dataWidth-1:0] pcNext;

    // sequential and branch candidates
    assign pcPlus4  = pc_o + dataWidth'(4);
    assign pcTarget = pc_o + immExt_i;

    assign pcNext = pcSrc_i ? pcTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc_o <= '0;
        end else begin
            pc_o <= pcNext;
        end
    end

endmodule

// ==== instrRom.sv ====
module instrRom import rvPkg::*; #(
    parameter int dataWidth = 32,
    parameter int romWords  = 64
) (
    input  wordT addr_i,
    output wordT instr_o
);

    localparam int addrBits = $clog2(romWords);

    logic [dataWidth-1:0] mem [romWords];

    // program image, one word per line
    initial begin
        $readmemh("program.hex", mem);
    end

    // word addressed, byte offset dropped
    assign instr_o = mem[addr_i[addrBits+1:2]];

endmodule

// ==== controlDecoder.sv ====
module controlDecoder import rvPkg::*; (
    input  logic [6:0] opcode_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7b5_i,
    output logic       regWriteEn_o,
    output logic       memWriteEn_o,
    output logic       aluSrc_o,
    output logic       branchEn_o,
    output logic       byteAccess_o,
    output logic       resultSrc_o,
    output aluCtrlT    aluCtrl_o,
    output immSrcT     immSrc_o
);

    opcodeT op;

    // funct3 to alu operation, subSel only for register ops
    function automatic aluCtrlT decodeAlu(input logic [2:0] f3, input logic subSel);
        aluCtrlT ctrl;
        case (f3)
            f3AddSub: ctrl = subSel ? aluSub : aluAdd;
            f3Slt:    ctrl = aluSlt;
            f3Or:     ctrl = aluOr;
            f3And:    ctrl = aluAnd;
            default:  ctrl = aluAdd;
        endcase
        return ctrl;
    endfunction

    assign op = opcodeT'(opcode_i);

    always_comb begin
        // safe defaults, nothing written
        regWriteEn_o = 1'b0;
        memWriteEn_o = 1'b0;
        aluSrc_o     = 1'b0;
        branchEn_o   = 1'b0;
        byteAccess_o = 1'b0;
        resultSrc_o  = 1'b0;
        aluCtrl_o    = aluAdd;
        immSrc_o     = immI;

        case (op)
            opR: begin
                regWriteEn_o = 1'b1;
                aluCtrl_o    = decodeAlu(funct3_i, funct7b5_i);
            end
            opI: begin
                // bit 30 belongs to the immediate here
                regWriteEn_o = 1'b1;
                aluSrc_o     = 1'b1;
                aluCtrl_o    = decodeAlu(funct3_i, 1'b0);
            end
            opLoad: begin
                regWriteEn_o = 1'b1;
                aluSrc_o     = 1'b1;
                resultSrc_o  = 1'b1;
                byteAccess_o = (funct3_i[1:0] == 2'b00);
            end
            opStore: begin
                memWriteEn_o = 1'b1;
                aluSrc_o     = 1'b1;
                immSrc_o     = immS;
                byteAccess_o = (funct3_i[1:0] == 2'b00);
            end
            opBranch: begin
                branchEn_o = 1'b1;
                aluCtrl_o  = aluSub;
                immSrc_o   = immB;
            end
            opLui: begin
                regWriteEn_o = 1'b1;
                aluSrc_o     = 1'b1;
                aluCtrl_o    = aluPassB;
                immSrc_o     = immU;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== regFile.sv ====
module regFile import rvPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic   clk,
    input  logic   rstN_i,
    input  regIdxT rs1_i,
    input  regIdxT rs2_i,
    input  regIdxT rd_i,
    input  logic   we_i,
    input  wordT   wd_i,
    output wordT   rd1_o,
    output wordT   rd2_o,
    output wordT   a0_o,
    output wordT   a1_o
);

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            // x0 never written, so it reads as zero
            regs[rd_i] <= wd_i;
        end
    end

    // combinational read ports
    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

    // argument registers x10 and x11
    assign a0_o = regs[10];
    assign a1_o = regs[11];

endmodule

// ==== immExtend.sv ====
module immExtend import rvPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic [24:0] immBits_i,
    input  immSrcT      immSrc_i,
    output wordT        immExt_o
);

    // immBits_i[k] is instruction bit k+7
    always_comb begin
        case (immSrc_i)
            immI: begin
                immExt_o = {{(dataWidth-12){immBits_i[24]}}, immBits_i[24:13]};
            end
            immS: begin
                immExt_o = {{(dataWidth-12){immBits_i[24]}}, immBits_i[24:18],
                            immBits_i[4:0]};
            end
            immB: begin
                // offset in halfwords, bit 0 always zero
                immExt_o = {{(dataWidth-13){immBits_i[24]}}, immBits_i[24], immBits_i[0],
                            immBits_i[23:18], immBits_i[4:1], 1'b0};
            end
            immU: begin
                immExt_o = {immBits_i[24:5], {(dataWidth-20){1'b0}}};
            end
            default: begin
                immExt_o = '0;
            end
        endcase
    end

endmodule

// ==== alu.sv ====
module alu import rvPkg::*; #(
    parameter int dataWidth = 32
) (
    input  wordT       srcA_i,
    input  wordT       srcB_i,
    input  aluCtrlT    aluCtrl_i,
    input  logic [2:0] funct3_i,
    output wordT       result_o,
    output logic       branchTaken_o
);

    logic [dataWidth-1:0] diff;
    logic                 lessThan;
    logic                 equal;

    assign diff     = srcA_i - srcB_i;
    assign lessThan = $signed(srcA_i) < $signed(srcB_i);
    assign equal    = (diff == '0);

    always_comb begin
        case (aluCtrl_i)
            aluAdd: begin
                result_o = srcA_i + srcB_i;
            end
            aluSub: begin
                result_o = diff;
            end
            aluAnd: begin
                result_o = srcA_i & srcB_i;
            end
            aluOr: begin
                result_o = srcA_i | srcB_i;
            end
            aluSlt: begin
                result_o = {{(dataWidth-1){1'b0}}, lessThan};
            end
            aluPassB: begin
                // lui result is the shifted immediate
                result_o = srcB_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (funct3_i)
            f3Beq:   branchTaken_o = equal;
            f3Bne:   branchTaken_o = !equal;
            default: branchTaken_o = 1'b0;
        endcase
    end

endmodule

// ==== dataRam.sv ====
module dataRam import rvPkg::*; #(
    parameter int dataWidth = 32,
    parameter int ramBytes  = 256
) (
    input  logic clk,
    input  logic we_i,
    input  logic byteAccess_i,
    input  wordT addr_i,
    input  wordT wd_i,
    output wordT rd_o
);

    localparam int addrBits = $clog2(ramBytes);

    logic [7:0]          mem [ramBytes];
    logic [addrBits-1:0] b0;
    logic [addrBits-1:0] b1;
    logic [addrBits-1:0] b2;
    logic [addrBits-1:0] b3;

    // little endian, lowest address holds the low byte
    assign b0 = addr_i[addrBits-1:0];
    assign b1 = b0 + 1'b1;
    assign b2 = b0 + 2'd2;
    assign b3 = b0 + 2'd3;

    // byte loads are zero extended
    assign rd_o = byteAccess_i ? {{(dataWidth-8){1'b0}}, mem[b0]}
                               : {mem[b3], mem[b2], mem[b1], mem[b0]};

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[b0] <= wd_i[7:0];
            if (!byteAccess_i) begin
                mem[b1] <= wd_i[15:8];
                mem[b2] <= wd_i[23:16];
                mem[b3] <= wd_i[31:24];
            end
        end
    end

endmodule

// ==== cpuTop.sv ====
module cpuTop import rvPkg::*; #(
    parameter int dataWidth = 32,
    parameter int romWords  = 64,
    parameter int ramBytes  = 256
) (
    input  logic clk,
    input  logic rstN_i,
    output wordT pc_o,
    output wordT instr_o,
    output wordT a0_o,
    output wordT a1_o
);

    // decoded fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    regIdxT      rs1;
    regIdxT      rs2;
    regIdxT      rd;
    logic [24:0] immBits;

    // control
    logic    regWriteEn;
    logic    memWriteEn;
    logic    aluSrc;
    logic    branchEn;
    logic    byteAccess;
    logic    resultSrc;
    aluCtrlT aluCtrl;
    immSrcT  immSrc;

    // datapath
    wordT rd1;
    wordT rd2;
    wordT immExt;
    wordT srcB;
    wordT aluResult;
    wordT readData;
    wordT result;
    logic branchTaken;
    logic pcSrc;

    fetchUnit #(.dataWidth(dataWidth)) uFetch (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .pcSrc_i  (pcSrc),
        .immExt_i (immExt),
        .pc_o     (pc_o)
    );

    instrRom #(.dataWidth(dataWidth), .romWords(romWords)) uRom (
        .addr_i  (pc_o),
        .instr_o (instr_o)
    );

    assign opcode   = instr_o[6:0];
    assign rd       = instr_o[11:7];
    assign funct3   = instr_o[14:12];
    assign rs1      = instr_o[19:15];
    assign rs2      = instr_o[24:20];
    assign funct7b5 = instr_o[30];
    assign immBits  = instr_o[31:7];

    controlDecoder uDecoder (
        .opcode_i     (opcode),
        .funct3_i     (funct3),
        .funct7b5_i   (funct7b5),
        .regWriteEn_o (regWriteEn),
        .memWriteEn_o (memWriteEn),
        .aluSrc_o     (aluSrc),
        .branchEn_o   (branchEn),
        .byteAccess_o (byteAccess),
        .resultSrc_o  (resultSrc),
        .aluCtrl_o    (aluCtrl),
        .immSrc_o     (immSrc)
    );

    regFile #(.dataWidth(dataWidth)) uRegs (
        .clk    (clk),
        .rstN_i (rstN_i),
        .rs1_i  (rs1),
        .rs2_i  (rs2),
        .rd_i   (rd),
        .we_i   (regWriteEn),
        .wd_i   (result),
        .rd1_o  (rd1),
        .rd2_o  (rd2),
        .a0_o   (a0_o),
        .a1_o   (a1_o)
    );

    immExtend #(.dataWidth(dataWidth)) uImm (
        .immBits_i (immBits),
        .immSrc_i  (immSrc),
        .immExt_o  (immExt)
    );

    // operand b is register or immediate
    assign srcB = aluSrc ? immExt : rd2;

    alu #(.dataWidth(dataWidth)) uAlu (
        .srcA_i        (rd1),
        .srcB_i        (srcB),
        .aluCtrl_i     (aluCtrl),
        .funct3_i      (funct3),
        .result_o      (aluResult),
        .branchTaken_o (branchTaken)
    );

    assign pcSrc = branchEn & branchTaken;

    dataRam #(.dataWidth(dataWidth), .ramBytes(ramBytes)) uRam (
        .clk          (clk),
        .we_i         (memWriteEn),
        .byteAccess_i (byteAccess),
        .addr_i       (aluResult),
        .wd_i         (rd2),
        .rd_o         (readData)
    );

    // loads write back memory data, everything else the alu result
    assign result = resultSrc ? readData : aluResult;

endmodule

// ==== tb_cpuTop.sv ====
module tb_cpuTop import rvPkg::*; ();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 3;

    logic clk;
    logic rstN;
    wordT pc;
    wordT instr;
    wordT a0;
    wordT a1;

    // one entry per checkpoint row in each queue
    string rowName[$];
    int    rowEdges[$];
    wordT  rowPc[$];
    wordT  rowA0[$];
    wordT  rowA1[$];

    // reference state used while the table is built
    wordT     mPc;
    wordT     mA0;
    wordT     mA1;
    int       mEdges;
    wordT     memWord;
    logic [7:0] memByte;

    int   timeLimit;
    logic tableReady = 1'b0;

    cpuTop #(
        .dataWidth (32),
        .romWords  (64),
        .ramBytes  (256)
    ) DUT (
        .clk     (clk),
        .rstN_i  (rstN),
        .pc_o    (pc),
        .instr_o (instr),
        .a0_o    (a0),
        .a1_o    (a1)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // hand-assembled test program, looked up by byte address
    function automatic wordT programWord(input wordT addr);
        wordT word;
        case (addr[6:2])
            5'd0:    word = 32'h00000513;
            5'd1:    word = 32'h00a00593;
            5'd2:    word = 32'h00b50533;
            5'd3:    word = 32'hfff58593;
            5'd4:    word = 32'hfe059ce3;
            5'd5:    word = 32'h40a585b3;
            5'd6:    word = 32'h00b56533;
            5'd7:    word = 32'h00a5a533;
            5'd8:    word = 32'h00a5f5b3;
            5'd9:    word = 32'h12345537;
            5'd10:   word = 32'h67850513;
            5'd11:   word = 32'h00a02823;
            5'd12:   word = 32'h01002583;
            5'd13:   word = 32'hfab00513;
            5'd14:   word = 32'h00a00a23;
            5'd15:   word = 32'h01404583;
            5'd16:   word = 32'h00b58463;
            5'd17:   word = 32'h00100513;
            5'd18:   word = 32'h00158593;
            5'd19:   word = 32'h00000063;
            default: word = 'x;
        endcase
        return word;
    endfunction

    task automatic pushRow(input string name);
        rowName.push_back(name);
        rowEdges.push_back(mEdges);
        rowPc.push_back(mPc);
        rowA0.push_back(mA0);
        rowA1.push_back(mA1);
    endtask

    // one instruction retires per rising edge
    task automatic retire(input string name, input wordT nextPc);
        mPc = nextPc;
        mEdges = mEdges + 1;
        pushRow(name);
    endtask

    task automatic buildTable();
        int iter;
        mPc = '0;
        mA0 = '0;
        mA1 = '0;
        mEdges = 0;
        pushRow("reset");
        mA0 = 32'd0;
        retire("addi a0", mPc + 32'd4);
        mA1 = 32'd10;
        retire("addi a1", mPc + 32'd4);
        // sum of a1 down to 1 into a0
        for (iter = 1; iter <= 10; iter++) begin
            mA0 = mA0 + mA1;
            retire($sformatf("add iter %0d", iter), mPc + 32'd4);
            mA1 = mA1 - 32'd1;
            retire($sformatf("addi iter %0d", iter), mPc + 32'd4);
            // taken bne jumps 8 bytes back to the loop top
            retire($sformatf("bne iter %0d", iter), (mA1 != 32'd0) ? mPc - 32'd8 : mPc + 32'd4);
        end
        mA1 = mA1 - mA0;
        retire("sub", mPc + 32'd4);
        mA0 = mA0 | mA1;
        retire("or", mPc + 32'd4);
        mA0 = ($signed(mA1) < $signed(mA0)) ? 32'd1 : 32'd0;
        retire("slt", mPc + 32'd4);
        mA1 = mA1 & mA0;
        retire("and", mPc + 32'd4);
        mA0 = 32'h12345 << 12;
        retire("lui", mPc + 32'd4);
        mA0 = mA0 + 32'h678;
        retire("addi low bits", mPc + 32'd4);
        memWord = mA0;
        retire("sw", mPc + 32'd4);
        mA1 = memWord;
        retire("lw", mPc + 32'd4);
        mA0 = 32'd0 - 32'd85;
        retire("addi -85", mPc + 32'd4);
        memByte = mA0[7:0];
        retire("sb", mPc + 32'd4);
        // lbu fills the upper bits with zeros
        mA1 = {24'd0, memByte};
        retire("lbu", mPc + 32'd4);
        // always taken so offset 8 jumps over the poisoning addi
        retire("beq taken", mPc + 32'd8);
        mA1 = mA1 + 32'd1;
        retire("addi after skip", mPc + 32'd4);
        // program ends in a branch to itself
        retire("halt 1", mPc);
        retire("halt 2", mPc);
    endtask

    task automatic checkValue(input string testName, input string what,
                              input wordT expVal, input wordT actVal);
        assert (actVal === expVal) else begin
            $display("MISMATCH %s %s expected 0x%08h actual 0x%08h",
                     testName, what, expVal, actVal);
            $display("Test FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // watchdog sized from the last checkpoint plus the reset phase
    initial begin
        wait (tableReady);
        #(timeLimit);
        $display("timeout: the run did not reach its last checkpoint in %0d time units",
                 timeLimit);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int edgesDone;
        int row;
        clk = 1'b0;
        rstN = 1'b0;
        buildTable();
        timeLimit = (resetCycles + rowEdges[rowEdges.size() - 1] + 10) * clkPeriod;
        tableReady = 1'b1;

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        edgesDone = 0;

        for (row = 0; row < rowName.size(); row++) begin
            if (edgesDone < rowEdges[row]) begin
                repeat (rowEdges[row] - edgesDone) @(posedge clk);
                edgesDone = rowEdges[row];
                // sample away from the active edge
                @(negedge clk);
            end
            checkValue(rowName[row], "pc", rowPc[row], pc);
            checkValue(rowName[row], "instr", programWord(rowPc[row]), instr);
            checkValue(rowName[row], "a0", rowA0[row], a0);
            checkValue(rowName[row], "a1", rowA1[row], a1);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== program.hex ====
// one 32-bit instruction word per line, word 0 at address 0
00000513 // 0x00 addi a0, x0, 0
00a00593 // 0x04 addi a1, x0, 10
00b50533 // 0x08 add  a0, a0, a1   loop top
fff58593 // 0x0c addi a1, a1, -1
fe059ce3 // 0x10 bne  a1, x0, -8
40a585b3 // 0x14 sub  a1, a1, a0
00b56533 // 0x18 or   a0, a0, a1
00a5a533 // 0x1c slt  a0, a1, a0
00a5f5b3 // 0x20 and  a1, a1, a0
12345537 // 0x24 lui  a0, 0x12345
67850513 // 0x28 addi a0, a0, 0x678
00a02823 // 0x2c sw   a0, 16(x0)
01002583 // 0x30 lw   a1, 16(x0)
fab00513 // 0x34 addi a0, x0, -85
00a00a23 // 0x38 sb   a0, 20(x0)
01404583 // 0x3c lbu  a1, 20(x0)
00b58463 // 0x40 beq  a1, a1, +8
00100513 // 0x44 addi a0, x0, 1    skipped
00158593 // 0x48 addi a1, a1, 1
00000063 // 0x4c beq  x0, x0, 0    halt

// ==== list.f ====
rvPkg.sv
fetchUnit.sv
instrRom.sv
controlDecoder.sv
regFile.sv
immExtend.sv
alu.sv
dataRam.sv
cpuTop.sv
tb_cpuTop.sv
